// ==== list.f ====
logic/angler_pkg.sv
logic/game_control.sv
logic/cursor_axis.sv
logic/crab_walker.sv
logic/fish_mover.sv
logic/readout_display.sv
logic/angler_top.sv
testbench/angler_tb.sv

// ==== logic/angler_pkg.sv ====
// Fishing game shared definitions
`default_nettype none

package angler_pkg;

    typedef logic [9:0]  pos_t;          // pond pixels
    typedef logic [13:0] fine_pos_t;     // tenths of a pixel
    typedef logic [8:0]  mouse_delta_t;  // two's complement
    typedef logic [9:0]  play_time_t;

    typedef enum logic {WAY_LEFT = 1'b0, WAY_RIGHT = 1'b1} way_t;
    typedef enum logic [1:0] {FISH_LEFT = 2'd0, FISH_RIGHT = 2'd1, FISH_HOOKED = 2'd2} fish_mode_t;
    typedef enum logic {BAIT_NORMAL = 1'b0, BAIT_CUT = 1'b1} bait_mode_t;

    localparam fine_pos_t CURSOR_H_MAX   = 14'd6400;
    localparam fine_pos_t CURSOR_V_MAX   = 14'd4800;
    localparam fine_pos_t CURSOR_H_START = 14'd3200;
    localparam fine_pos_t CURSOR_V_START = 14'd2400;

    localparam play_time_t PLAY_WRAP = 10'd500;

    // crab lanes
    localparam logic [7:0] CRAB_LANE_PATTERN = 8'b10110010;
    localparam pos_t LANE_V_BASE     = 10'd240;
    localparam pos_t LANE_V_PITCH    = 10'd30;
    localparam pos_t CRAB_RIGHT_EDGE = 10'd670;
    localparam pos_t CRAB_START_H    = 10'd700;

    localparam pos_t CUT_H_LO = 10'd279;
    localparam pos_t CUT_H_HI = 10'd309;
    localparam int   CUT_SECONDS = 3;

    // fish and hook
    localparam pos_t HOOK_H        = 10'd298;
    localparam pos_t REEL_DEPTH    = 10'd62;
    localparam pos_t HOOK_LEFT_LO  = 10'd314;
    localparam pos_t HOOK_LEFT_HI  = 10'd325;
    localparam pos_t HOOK_RIGHT_LO = 10'd274;
    localparam pos_t HOOK_RIGHT_HI = 10'd285;
    localparam pos_t HOOK_V_ABOVE  = 10'd5;
    localparam pos_t HOOK_V_BELOW  = 10'd25;
    localparam pos_t FISH_LEFT_WRAP  = 10'd700;
    localparam pos_t FISH_RIGHT_WRAP = 10'd720;
    localparam pos_t FISH_SPAWN_V    = 10'd400;
    localparam pos_t FISH_START_H    = 10'd400;
    localparam pos_t FISH_START_V    = 10'd320;

endpackage

`default_nettype wire

// ==== logic/angler_top.sv ====
// Fishing game top level
`timescale 1ns/1ps
`default_nettype none

module angler_top #(
    parameter int TICKS_PER_SECOND = 100_000_000,
    parameter int STEP_DIV = 524_288,
    parameter int SCAN_DIV = 8192,
    parameter int TOTAL_TIME = 300
) (
    input  logic clk,
    input  logic rst,
    input  angler_pkg::mouse_delta_t mouse_dx,
    input  angler_pkg::mouse_delta_t mouse_dy,
    input  logic mouse_left,
    input  logic mouse_valid,
    input  logic play,
    input  logic pause,
    input  logic freeze,
    input  angler_pkg::way_t fish_way_in,
    input  logic [3:0] sw,
    output logic [6:0] seg,
    output logic [3:0] digit_sel,
    output logic line_cut
);
    import angler_pkg::*;

    logic       step_tick;
    play_time_t play_time;
    pos_t       line_depth;
    bait_mode_t bait_mode;
    fine_pos_t  cursor_h;
    fine_pos_t  cursor_v;
    pos_t       crab1_h;
    pos_t       crab1_v;
    pos_t       crab2_h;
    pos_t       crab2_v;
    logic       crab1_appear;
    logic       crab2_appear;
    pos_t       fish_h;
    pos_t       fish_v;

    assign line_cut = (bait_mode == BAIT_CUT);

    game_control #(.TICKS_PER_SECOND(TICKS_PER_SECOND), .STEP_DIV(STEP_DIV)) game_control_i (
        .clk(clk), .rst(rst), .play(play), .pause(pause),
        .crab1_h(crab1_h), .crab1_v(crab1_v), .crab2_h(crab2_h), .crab2_v(crab2_v),
        .crab1_appear(crab1_appear), .crab2_appear(crab2_appear), .cursor_v(cursor_v),
        .second_tick(), .step_tick(step_tick), .play_time(play_time),
        .line_depth(line_depth), .bait_mode(bait_mode)
    );

    cursor_axis #(.LIMIT(CURSOR_H_MAX), .START(CURSOR_H_START), .DOWN_POSITIVE(1'b1)) cursor_h_i (
        .clk(clk), .rst(rst), .mouse_valid(mouse_valid), .delta(mouse_dx), .pos(cursor_h)
    );

    // mouse up raises the line
    cursor_axis #(.LIMIT(CURSOR_V_MAX), .START(CURSOR_V_START), .DOWN_POSITIVE(1'b0)) cursor_v_i (
        .clk(clk), .rst(rst), .mouse_valid(mouse_valid), .delta(mouse_dy), .pos(cursor_v)
    );

    crab_walker #(
        .APPEAR_TIME(10), .START_V(380), .START_LANE(0), .START_WAY(WAY_LEFT),
        .LANE_STEP(3), .FLIP_WAY(1'b0)
    ) crab1_i (
        .clk(clk), .rst(rst), .step_tick(step_tick), .pause(pause), .play_time(play_time),
        .h(crab1_h), .v(crab1_v), .way(), .appear(crab1_appear)
    );

    crab_walker #(
        .APPEAR_TIME(12), .START_V(250), .START_LANE(4), .START_WAY(WAY_RIGHT),
        .LANE_STEP(5), .FLIP_WAY(1'b1)
    ) crab2_i (
        .clk(clk), .rst(rst), .step_tick(step_tick), .pause(pause), .play_time(play_time),
        .h(crab2_h), .v(crab2_v), .way(), .appear(crab2_appear)
    );

    fish_mover fish_mover_i (
        .clk(clk), .rst(rst), .step_tick(step_tick), .freeze(freeze), .mouse_left(mouse_left),
        .fish_way_in(fish_way_in), .line_depth(line_depth), .bait_mode(bait_mode),
        .fish_h(fish_h), .fish_v(fish_v), .fish_mode()
    );

    readout_display #(.SCAN_DIV(SCAN_DIV), .TOTAL_TIME(TOTAL_TIME)) readout_display_i (
        .clk(clk), .rst(rst), .sw(sw), .play_time(play_time),
        .fish_h(fish_h), .fish_v(fish_v), .crab1_h(crab1_h), .crab1_v(crab1_v),
        .crab2_h(crab2_h), .crab2_v(crab2_v), .cursor_h(cursor_h), .cursor_v(cursor_v),
        .seg(seg), .digit_sel(digit_sel)
    );

endmodule

`default_nettype wire

// ==== logic/crab_walker.sv ====
// Crab walking across the lanes
`timescale 1ns/1ps
`default_nettype none

module crab_walker #(
    parameter int APPEAR_TIME = 10,
    parameter int START_V = 380,
    parameter int START_LANE = 0,
    parameter angler_pkg::way_t START_WAY = angler_pkg::WAY_LEFT,
    parameter int LANE_STEP = 3,
    parameter bit FLIP_WAY = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  logic step_tick,
    input  logic pause,
    input  angler_pkg::play_time_t play_time,
    output angler_pkg::pos_t h,
    output angler_pkg::pos_t v,
    output angler_pkg::way_t way,
    output logic appear
);
    import angler_pkg::*;

    logic [2:0] lane;
    logic [2:0] next_lane;
    way_t       next_way;
    logic       at_edge;

    assign next_lane = lane + 3'(LANE_STEP);  // wraps mod 8
    assign next_way  = way_t'(CRAB_LANE_PATTERN[next_lane] ^ FLIP_WAY);
    assign at_edge   = (way == WAY_LEFT) ? (h == '0) : (h == CRAB_RIGHT_EDGE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h      <= CRAB_START_H;
            v      <= pos_t'(START_V);
            way    <= START_WAY;
            lane   <= 3'(START_LANE);
            appear <= 1'b0;
        end else if (!appear) begin
            if (play_time == play_time_t'(APPEAR_TIME)) begin
                h      <= CRAB_START_H;
                v      <= pos_t'(START_V);
                way    <= START_WAY;
                lane   <= 3'(START_LANE);
                appear <= 1'b1;
            end
        end else if (step_tick && !pause) begin
            if (at_edge) begin
                lane <= next_lane;
                way  <= next_way;
                v    <= LANE_V_BASE + LANE_V_PITCH * next_lane;
                h    <= (next_way == WAY_LEFT) ? CRAB_RIGHT_EDGE : '0;
            end else if (way == WAY_LEFT) begin
                h <= h - 1'b1;
            end else begin
                h <= h + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cursor_axis.sv ====
// Clamped cursor axis
`timescale 1ns/1ps
`default_nettype none

module cursor_axis #(
    parameter int LIMIT = 6400,
    parameter int START = 3200,
    parameter bit DOWN_POSITIVE = 1'b1
) (
    input  logic clk,
    input  logic rst,
    input  logic mouse_valid,
    input  angler_pkg::mouse_delta_t delta,
    output angler_pkg::fine_pos_t pos
);
    import angler_pkg::*;

    logic [7:0]  mag;
    logic [8:0]  step;
    logic        toward_limit;
    logic [14:0] sum;

    // ones' complement magnitude on negative reports
    assign mag          = delta[8] ? ~delta[7:0] : delta[7:0];
    assign step         = {mag, 1'b0};
    assign toward_limit = delta[8] ^ DOWN_POSITIVE;
    assign sum          = {1'b0, pos} + 15'(step);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos <= fine_pos_t'(START);
        end else if (mouse_valid) begin
            if (toward_limit) begin
                pos <= (sum >= 15'(LIMIT)) ? fine_pos_t'(LIMIT) : sum[13:0];
            end else begin
                pos <= (pos < 14'(step)) ? '0 : pos - 14'(step);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fish_mover.sv ====
// Fish swimming and reeling
`timescale 1ns/1ps
`default_nettype none

module fish_mover (
    input  logic clk,
    input  logic rst,
    input  logic step_tick,
    input  logic freeze,
    input  logic mouse_left,
    input  angler_pkg::way_t fish_way_in,
    input  angler_pkg::pos_t line_depth,
    input  angler_pkg::bait_mode_t bait_mode,
    output angler_pkg::pos_t fish_h,
    output angler_pkg::pos_t fish_v,
    output angler_pkg::fish_mode_t fish_mode
);
    import angler_pkg::*;

    pos_t        reel_v;
    logic [10:0] depth_ext;
    logic [10:0] v_ext;
    logic        near_line;
    logic        in_window;
    logic        hook_now;
    logic        catch_now;

    assign reel_v    = (line_depth > REEL_DEPTH) ? line_depth : REEL_DEPTH;
    assign depth_ext = {1'b0, line_depth};
    assign v_ext     = {1'b0, fish_v};
    assign near_line = (depth_ext + 11'(HOOK_V_ABOVE) >= v_ext) &&
                       (depth_ext <= v_ext + 11'(HOOK_V_BELOW));

    always_comb begin
        case (fish_mode)
            FISH_LEFT:  in_window = (fish_h >= HOOK_LEFT_LO) && (fish_h <= HOOK_LEFT_HI);
            FISH_RIGHT: in_window = (fish_h >= HOOK_RIGHT_LO) && (fish_h <= HOOK_RIGHT_HI);
            default:    in_window = 1'b0;
        endcase
    end

    assign hook_now  = in_window && near_line && (bait_mode == BAIT_NORMAL);
    assign catch_now = (fish_mode == FISH_HOOKED) && (bait_mode == BAIT_NORMAL) &&
                       mouse_left && (line_depth <= REEL_DEPTH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fish_mode <= FISH_LEFT;
            fish_h    <= FISH_START_H;
            fish_v    <= FISH_START_V;
        end else if (hook_now) begin
            fish_mode <= FISH_HOOKED;
            fish_h    <= HOOK_H;
            fish_v    <= reel_v;
        end else if (fish_mode == FISH_HOOKED) begin
            if (catch_now) begin
                fish_mode <= fish_mode_t'({1'b0, fish_way_in});  // fresh fish
                fish_v    <= FISH_SPAWN_V;
                fish_h    <= (fish_way_in == WAY_LEFT) ? FISH_LEFT_WRAP : '0;
            end else begin
                fish_h <= HOOK_H;
                fish_v <= reel_v;
            end
        end else if (step_tick && !freeze) begin
            if (fish_mode == FISH_LEFT) begin
                fish_h <= (fish_h == '0) ? FISH_LEFT_WRAP : fish_h - 1'b1;
            end else begin
                fish_h <= (fish_h == FISH_RIGHT_WRAP) ? '0 : fish_h + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/game_control.sv ====
// Play clock and line state
`timescale 1ns/1ps
`default_nettype none

module game_control #(
    parameter int TICKS_PER_SECOND = 100_000_000,
    parameter int STEP_DIV = 524_288
) (
    input  logic clk,
    input  logic rst,
    input  logic play,
    input  logic pause,
    input  angler_pkg::pos_t crab1_h,
    input  angler_pkg::pos_t crab1_v,
    input  angler_pkg::pos_t crab2_h,
    input  angler_pkg::pos_t crab2_v,
    input  logic crab1_appear,
    input  logic crab2_appear,
    input  angler_pkg::fine_pos_t cursor_v,
    output logic second_tick,
    output logic step_tick,
    output angler_pkg::play_time_t play_time,
    output angler_pkg::pos_t line_depth,
    output angler_pkg::bait_mode_t bait_mode
);
    import angler_pkg::*;

    localparam int SEC_W  = $clog2(TICKS_PER_SECOND + 1);
    localparam int STEP_W = $clog2(STEP_DIV + 1);

    logic              run;
    logic [SEC_W-1:0]  sec_cnt;
    logic [STEP_W-1:0] step_cnt;
    logic [1:0]        cut_cnt;
    pos_t              cut_v;
    logic              depth_held;
    logic              held_now;
    logic              crab1_cut;
    logic              crab2_cut;

    // a crab in the window above the line, or above the recorded cut
    function automatic logic crab_hits(input logic appear, input pos_t h, input pos_t v,
                                       input logic held, input pos_t depth, input pos_t rec);
        logic in_window;
        in_window = appear && (h >= CUT_H_LO) && (h <= CUT_H_HI);
        return held ? (in_window && (v < rec)) : (in_window && (v <= depth));
    endfunction

    assign run        = play & ~pause;
    assign line_depth = pos_t'(cursor_v / 14'd10);
    assign held_now   = (bait_mode == BAIT_CUT) && depth_held;
    assign crab1_cut  = crab_hits(crab1_appear, crab1_h, crab1_v, held_now, line_depth, cut_v);
    assign crab2_cut  = crab_hits(crab2_appear, crab2_h, crab2_v, held_now, line_depth, cut_v);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sec_cnt     <= '0;
            step_cnt    <= '0;
            second_tick <= 1'b0;
            step_tick   <= 1'b0;
        end else if (!run) begin
            sec_cnt     <= '0;  // prescalers restart on resume
            step_cnt    <= '0;
            second_tick <= 1'b0;
            step_tick   <= 1'b0;
        end else begin
            second_tick <= (sec_cnt == SEC_W'(TICKS_PER_SECOND - 1));
            sec_cnt     <= (sec_cnt == SEC_W'(TICKS_PER_SECOND - 1)) ? '0 : sec_cnt + 1'b1;
            step_tick   <= (step_cnt == STEP_W'(STEP_DIV - 1));
            step_cnt    <= (step_cnt == STEP_W'(STEP_DIV - 1)) ? '0 : step_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            play_time <= '0;
        end else if (!play) begin
            play_time <= '0;
        end else if (second_tick) begin
            play_time <= (play_time == PLAY_WRAP) ? '0 : play_time + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bait_mode  <= BAIT_NORMAL;
            cut_cnt    <= '0;
            depth_held <= 1'b0;
        end else if (crab1_cut || crab2_cut) begin
            bait_mode  <= BAIT_CUT;
            cut_cnt    <= '0;
            depth_held <= 1'b1;
        end else if (bait_mode == BAIT_CUT) begin
            if (second_tick) begin
                if (cut_cnt == 2'(CUT_SECONDS - 1)) begin
                    bait_mode  <= BAIT_NORMAL;
                    depth_held <= 1'b0;
                end else begin
                    cut_cnt <= cut_cnt + 1'b1;
                end
            end
            if (depth_held && (line_depth < cut_v)) begin
                depth_held <= 1'b0;  // line pulled up past the cut
            end
        end
    end

    always_ff @(posedge clk) begin
        if (crab1_cut || crab2_cut) begin
            cut_v <= crab1_cut ? crab1_v : crab2_v;  // crab 1 first
        end
    end

endmodule

`default_nettype wire

// ==== logic/readout_display.sv ====
// Seven-segment readout
`timescale 1ns/1ps
`default_nettype none

module readout_display #(
    parameter int SCAN_DIV = 8192,
    parameter int TOTAL_TIME = 300
) (
    input  logic clk,
    input  logic rst,
    input  logic [3:0] sw,
    input  angler_pkg::play_time_t play_time,
    input  angler_pkg::pos_t fish_h,
    input  angler_pkg::pos_t fish_v,
    input  angler_pkg::pos_t crab1_h,
    input  angler_pkg::pos_t crab1_v,
    input  angler_pkg::pos_t crab2_h,
    input  angler_pkg::pos_t crab2_v,
    input  angler_pkg::fine_pos_t cursor_h,
    input  angler_pkg::fine_pos_t cursor_v,
    output logic [6:0] seg,
    output logic [3:0] digit_sel
);
    localparam int SCAN_W = $clog2(SCAN_DIV + 1);

    logic [SCAN_W-1:0] scan_cnt;
    logic [1:0]        digit_idx;  // 0 is the leftmost digit
    logic [13:0]       value;
    logic [10:0]       remain;
    logic [3:0]        digits [4];
    logic [3:0]        nibble;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == SCAN_W'(SCAN_DIV - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign remain = 11'(TOTAL_TIME) - {1'b0, play_time};

    always_comb begin
        case (sw[2:0])
            3'd0:    value = 14'(fish_v);
            3'd1:    value = 14'(fish_h);
            3'd2:    value = cursor_v;
            3'd3:    value = cursor_h;
            3'd4:    value = 14'(crab1_v);
            3'd5:    value = 14'(crab1_h);
            3'd6:    value = 14'(crab2_v);
            default: value = 14'(crab2_h);
        endcase
    end

    always_comb begin
        if (sw[3]) begin
            // m:ss countdown
            digits[0] = 4'd0;
            digits[1] = 4'(remain / 11'd60);
            digits[2] = 4'((remain % 11'd60) / 11'd10);
            digits[3] = 4'(remain % 11'd10);
        end else begin
            digits[0] = 4'(value / 14'd1000);
            digits[1] = 4'((value % 14'd1000) / 14'd100);
            digits[2] = 4'((value % 14'd100) / 14'd10);
            digits[3] = 4'(value % 14'd10);
        end
    end

    assign nibble = digits[digit_idx];

    always_comb begin
        case (digit_idx)
            2'd0:    digit_sel = 4'b0111;
            2'd1:    digit_sel = 4'b1011;
            2'd2:    digit_sel = 4'b1101;
            default: digit_sel = 4'b1110;
        endcase
    end

    always_comb begin
        case (nibble)
            4'd0:    seg = 7'b1000000;
            4'd1:    seg = 7'b1111001;
            4'd2:    seg = 7'b0100100;
            4'd3:    seg = 7'b0110000;
            4'd4:    seg = 7'b0011001;
            4'd5:    seg = 7'b0010010;
            4'd6:    seg = 7'b0000010;
            4'd7:    seg = 7'b1111000;
            4'd8:    seg = 7'b0000000;
            4'd9:    seg = 7'b0010000;
            default: seg = 7'b1111111;  // blank
        endcase
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator and run; status follows the pass line
cd "$(dirname "$0")" &&
    verilator --binary --timing -f list.f --top-module angler_tb -o angler_sim &&
    ./obj_dir/angler_sim | tee /dev/stderr | grep -qx '>>> PASS' ||
    { echo "simulation failed"; exit 1; }

// ==== testbench/angler_tb.sv ====
// Fishing game testbench
`timescale 1ns/1ps
`default_nettype none

module angler_tb;

    localparam int TOTAL = 300;
    localparam int SEC_LEN = 16;
    localparam int STEP_LEN = 2;
    localparam int CUT_SEC = 3;
    localparam logic [7:0] LANE_MAP = 8'b10110010;
    // summed test lengths in cycles plus margin
    localparam int CYCLE_LIMIT = 60 + 300 + 2100 + 600 + 1600 + 2000 + 500;

    logic clk;
    logic rst;
    logic [8:0] mouse_dx;
    logic [8:0] mouse_dy;
    logic mouse_left;
    logic mouse_valid;
    logic play;
    logic pause;
    logic freeze;
    angler_pkg::way_t fish_way_in;
    logic [3:0] sw;
    logic [6:0] seg;
    logic [3:0] digit_sel;
    logic line_cut;

    // mirrored game state
    int m_time;
    int m_sc;
    int m_sx;
    int m_cur_h;
    int m_cur_v;
    int m_crab1_h;
    int m_crab1_v;
    int m_lane1;
    int m_crab2_h;
    int m_crab2_v;
    int m_lane2;
    int m_fish_h;
    int m_cnt;
    int m_cut_v;
    bit m_sec;
    bit m_step;
    bit m_app;
    bit m_app2;
    bit m_way1;
    bit m_way2;
    bit m_cut;
    bit m_held;
    int errors;
    int checks;
    int cycles;
    int start_errs;
    int i;
    bit check_cut;
    string test_name;
    logic [31:0] rng;

    angler_top #(.TICKS_PER_SECOND(SEC_LEN), .STEP_DIV(STEP_LEN), .SCAN_DIV(4),
                 .TOTAL_TIME(TOTAL)) angler_top_i (
        .clk(clk), .rst(rst), .mouse_dx(mouse_dx), .mouse_dy(mouse_dy),
        .mouse_left(mouse_left), .mouse_valid(mouse_valid), .play(play), .pause(pause),
        .freeze(freeze), .fish_way_in(fish_way_in), .sw(sw), .seg(seg),
        .digit_sel(digit_sel), .line_cut(line_cut)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [3:0] seg_to_digit(input logic [6:0] s);
        case (s)
            7'b1000000: return 4'd0;
            7'b1111001: return 4'd1;
            7'b0100100: return 4'd2;
            7'b0110000: return 4'd3;
            7'b0011001: return 4'd4;
            7'b0010010: return 4'd5;
            7'b0000010: return 4'd6;
            7'b1111000: return 4'd7;
            7'b0000000: return 4'd8;
            7'b0010000: return 4'd9;
            default:    return 4'hf;  // unknown pattern
        endcase
    endfunction

    // one axis step with doubled magnitude and clamping at both ends
    function automatic int axis_next(input int pos, input logic [8:0] d, input int limit,
                                     input bit down_pos);
        logic [7:0] mag;
        int step;
        bit toward;
        mag = d[8] ? ~d[7:0] : d[7:0];
        step = 2 * int'(mag);
        toward = d[8] ? !down_pos : down_pos;
        if (toward) begin
            return (pos + step > limit) ? limit : pos + step;
        end
        return (pos < step) ? 0 : pos - step;
    endfunction

    // crab in the cut window above the line or above the recorded cut
    function automatic bit cuts_line(input bit app, input int h, input int v, input int depth);
        if (!app || h < 279 || h > 309) begin
            return 1'b0;
        end
        return m_held ? (v < m_cut_v) : (v <= depth);
    endfunction

    // one pixel of walking, or a turn into the next lane at the edge
    task automatic walk_crab(inout int h, inout int v, inout int lane, inout bit way,
                             input int lane_step, input bit flip);
        if (way ? (h == 670) : (h == 0)) begin
            lane = (lane + lane_step) % 8;
            way = LANE_MAP[lane] ^ flip;
            v = 240 + 30 * lane;
            h = way ? 0 : 670;
        end else if (way) begin
            h = (h + 1) % 1024;
        end else begin
            h = h - 1;
        end
    endtask

    function automatic logic [15:0] expected_bcd(input logic [3:0] sel);
        int val;
        int rem;
        if (sel[3]) begin
            rem = TOTAL - m_time;
            return {4'd0, 4'(rem / 60), 4'((rem % 60) / 10), 4'(rem % 10)};
        end
        case (sel[2:0])
            3'd0:    val = 320;  // fish depth while swimming
            3'd1:    val = m_fish_h;
            3'd2:    val = m_cur_v;
            3'd3:    val = m_cur_h;
            3'd4:    val = m_crab1_v;
            3'd5:    val = m_crab1_h;
            3'd6:    val = m_crab2_v;
            default: val = m_crab2_h;
        endcase
        return {4'(val / 1000), 4'((val % 1000) / 100), 4'((val % 100) / 10), 4'(val % 10)};
    endfunction

    // one clock edge with the mirror advanced by the inputs held over it
    task automatic tick();
        bit run;
        int depth;
        bit hit1;
        bit hit2;
        @(posedge clk);
        run = play && !pause;
        depth = m_cur_v / 10;
        hit1 = cuts_line(m_app, m_crab1_h, m_crab1_v, depth);
        hit2 = cuts_line(m_app2, m_crab2_h, m_crab2_v, depth);
        if (hit1 || hit2) begin
            m_cut = 1;
            m_held = 1;
            m_cnt = 0;
            m_cut_v = hit1 ? m_crab1_v : m_crab2_v;
        end else if (m_cut) begin
            if (m_sec) begin
                if (m_cnt == CUT_SEC - 1) begin
                    m_cut = 0;
                    m_held = 0;
                end else begin
                    m_cnt++;
                end
            end
            if (m_held && depth < m_cut_v) m_held = 0;
        end
        if (!m_app) begin
            if (m_time == 10) begin
                m_app = 1;
                m_crab1_h = 700;
            end
        end else if (m_step && !pause) begin
            walk_crab(m_crab1_h, m_crab1_v, m_lane1, m_way1, 3, 1'b0);
        end
        if (!m_app2) begin
            if (m_time == 12) begin
                m_app2 = 1;
                m_crab2_h = 700;
            end
        end else if (m_step && !pause) begin
            walk_crab(m_crab2_h, m_crab2_v, m_lane2, m_way2, 5, 1'b1);
        end
        if (m_step && !freeze) m_fish_h = (m_fish_h == 0) ? 700 : m_fish_h - 1;
        if (!play) m_time = 0;
        else if (m_sec) m_time = (m_time == 500) ? 0 : m_time + 1;
        m_sec = run && (m_sc == SEC_LEN - 1);
        m_sc = (!run || m_sc == SEC_LEN - 1) ? 0 : m_sc + 1;
        m_step = run && (m_sx == STEP_LEN - 1);
        m_sx = (!run || m_sx == STEP_LEN - 1) ? 0 : m_sx + 1;
        if (mouse_valid) begin
            m_cur_h = axis_next(m_cur_h, mouse_dx, 6400, 1'b1);
            m_cur_v = axis_next(m_cur_v, mouse_dy, 4800, 1'b0);
        end
        #1;
        if (check_cut) begin
            assert (line_cut == m_cut) else begin
                $display("FAIL %s line_cut expected %0d actual %0d",
                         test_name, m_cut, line_cut);
                errors++;
            end
        end
    endtask

    task automatic run_ticks(input int n);
        repeat (n) tick();
    endtask

    // capture the four digits of one full scan
    task automatic check_readout(input string name, input logic [3:0] sel);
        logic [15:0] got;
        logic [15:0] exp;
        logic [3:0] pat [4];
        int idx;
        int n;
        pat = '{4'b0111, 4'b1011, 4'b1101, 4'b1110};
        sw = sel;
        tick();
        idx = 0;
        n = 0;
        got = '0;
        while (digit_sel != 4'b0111 && n < 40) begin
            tick();
            n++;
        end
        while (idx < 4 && n < 80) begin
            if (digit_sel == pat[idx]) begin
                got[15 - 4 * idx -: 4] = seg_to_digit(seg);
                idx++;
            end else begin
                tick();
                n++;
            end
        end
        exp = expected_bcd(sel);
        checks++;
        assert (idx == 4) else begin
            $display("readout scan never completed during %s", name);
            errors++;
        end
        assert (got == exp) else begin
            $display("FAIL %s expected %h actual %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic send_mouse(input logic [8:0] dx, input logic [8:0] dy);
        mouse_dx = dx;
        mouse_dy = dy;
        mouse_valid = 1'b1;
        tick();
        mouse_valid = 1'b0;
        tick();
    endtask

    task automatic end_test();
        $display("test %s: %s", test_name, (errors == start_errs) ? "ok" : "errors seen");
        start_errs = errors;
    endtask

    // run limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        mouse_dx = '0;
        mouse_dy = '0;
        mouse_left = 1'b0;
        mouse_valid = 1'b0;
        play = 1'b0;
        pause = 1'b0;
        freeze = 1'b0;
        fish_way_in = angler_pkg::WAY_LEFT;
        sw = 4'b1000;
        m_time = 0;
        m_sc = 0;
        m_sx = 0;
        m_sec = 0;
        m_step = 0;
        m_cur_h = 3200;
        m_cur_v = 2400;
        m_crab1_h = 700;
        m_crab1_v = 380;
        m_lane1 = 0;
        m_way1 = 0;
        m_app = 0;
        m_crab2_h = 700;
        m_crab2_v = 250;
        m_lane2 = 4;
        m_way2 = 1;
        m_app2 = 0;
        m_fish_h = 400;
        m_cut = 0;
        m_held = 0;
        m_cnt = 0;
        m_cut_v = 0;
        errors = 0;
        checks = 0;
        start_errs = 0;
        check_cut = 1;
        rng = 32'd22386;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        test_name = "reset";
        check_readout("reset_countdown", 4'b1000);
        assert (line_cut == 1'b0) else begin
            $display("line_cut is high after reset");
            errors++;
        end
        end_test();

        test_name = "countdown";
        play = 1'b1;
        run_ticks(53);
        pause = 1'b1;
        check_readout("countdown_3s", 4'b1000);
        pause = 1'b0;
        run_ticks(40);
        pause = 1'b1;
        check_readout("countdown_paused", 4'b1000);
        check_readout("countdown_held", 4'b1000);
        play = 1'b0;
        pause = 1'b0;
        check_readout("countdown_stopped", 4'b1000);
        end_test();

        test_name = "cursor";
        for (i = 0; i < 34; i++) begin
            rng = xorshift(rng);
            if (i < 8) send_mouse(rng[8:0], rng[17:9]);
            else if (i < 21) send_mouse(9'h0ff, 9'h0ff);  // right edge and line to top
            else send_mouse(9'h100, 9'h100);  // left edge and line to bottom
            check_readout("cursor_v", 4'd2);
            check_readout("cursor_h", 4'd3);
        end
        end_test();

        test_name = "crab";
        play = 1'b1;
        run_ticks(100);
        pause = 1'b1;
        check_readout("crab_absent_h", 4'd5);
        pause = 1'b0;
        for (i = 0; i < 200 && !m_app; i++) tick();
        run_ticks(41);
        pause = 1'b1;
        check_readout("crab_walk_h", 4'd5);
        check_readout("crab_walk_v", 4'd4);
        pause = 1'b0;
        end_test();

        test_name = "line_cut";
        for (i = 0; i < 1200 && !m_cut; i++) tick();
        assert (m_cut) else begin
            $display("crab never reached the cut window");
            errors++;
        end
        for (i = 0; i < 200 && m_cut; i++) tick();
        run_ticks(2);
        check_cut = 0;
        end_test();

        test_name = "fish";
        freeze = 1'b1;
        run_ticks(60);
        check_readout("fish_frozen", 4'd1);
        run_ticks(60);
        check_readout("fish_still_frozen", 4'd1);
        freeze = 1'b0;
        for (i = 0; i < 1600 && m_fish_h != 700; i++) tick();
        assert (m_fish_h == 700) else begin
            $display("fish never wrapped to the right side");
            errors++;
        end
        run_ticks(10);
        pause = 1'b1;
        check_readout("fish_wrapped", 4'd1);
        end_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
